//--- bench/icache_fsm_asserts.sv
`timescale 1ns/100ps

module icache_fsm_asserts
    import icache_pkg::*;
(
    input logic       clk,
    input logic       rstn,
    input logic       r_req,
    input logic       cache_ready,
    input logic       cacop_complete,
    input way_mask_t  mem_we,
    input logic [2:0] state_q
);

    // Memory is only requested while the processor is stalled.
    req_while_ready: assert property (
        @(posedge clk) disable iff (!rstn) !(r_req && cache_ready)
    ) else $error("r_req is high while cache_ready is high");

    fill_one_way: assert property (
        @(posedge clk) disable iff (!rstn) $onehot0(mem_we)
    ) else $error("mem_we enables more than one way");

    complete_after_cacop: assert property (
        @(posedge clk) disable iff (!rstn) cacop_complete |-> $past(state_q) == state_cacop
    ) else $error("cacop_complete without a cacop cycle before it");

endmodule

bind icache_fsm icache_fsm_asserts u_fsm_asserts (
    .clk            (clk),
    .rstn           (rstn),
    .r_req          (r_req),
    .cache_ready    (cache_ready),
    .cacop_complete (cacop_complete),
    .mem_we         (mem_we),
    .state_q        (state_q)
);

//--- bench/icache_tb.sv
`timescale 1ns/100ps

module icache_tb
    import icache_pkg::*;
();

    logic         clk;
    logic         rstn;
    logic         valid;
    icache_addr_u addr;
    logic         uncache;
    logic         cacop_en;
    logic [1:0]   cacop_code;
    logic         exception;
    logic         cache_ready;
    logic         cacop_ready;
    logic         data_valid;
    logic [31:0]  rdata;
    logic         cacop_complete;
    logic         r_req;
    mem_req_t     mem_req;
    logic         r_rdy;
    logic         r_data_valid;
    logic [31:0]  r_data;

    // Reference model of tags, valid bits and tree bits per set.
    logic [tag_bits-1:0] model_tag [num_sets][num_ways];
    logic [num_ways-1:0] model_valid [num_sets];
    logic [2:0]          model_tree [num_sets];  // Root, leaf 0/1, leaf 2/3.

    // Expected response of the request in flight.
    logic        exp_mem;
    logic [31:0] exp_mem_addr;
    logic [7:0]  exp_len;
    logic [31:0] exp_rdata;
    logic        check_rdata;
    logic        exp_cacop;
    int          issue_mem_count;
    int          issued;
    int          answered;
    int          mem_count;
    int          error_count;
    int          start_errors;
    int          tests_run;
    int          tests_failed;
    string       current_test;

    tb_clock_gen u_clock_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    icache_top uut (
        .clk            (clk),
        .rstn           (rstn),
        .valid          (valid),
        .addr           (addr),
        .uncache        (uncache),
        .cacop_en       (cacop_en),
        .cacop_code     (cacop_code),
        .exception      (exception),
        .cache_ready    (cache_ready),
        .cacop_ready    (cacop_ready),
        .data_valid     (data_valid),
        .rdata          (rdata),
        .cacop_complete (cacop_complete),
        .r_req          (r_req),
        .mem_req        (mem_req),
        .r_rdy          (r_rdy),
        .r_data_valid   (r_data_valid),
        .r_data         (r_data)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] line_addr(input logic [23:0] tag, input logic [3:0] set,
                                              input logic [1:0] word);
        return {tag, set, word, 2'b00};
    endfunction

    function automatic logic [31:0] maint_addr(input logic [3:0] set, input logic [1:0] way);
        return {24'h000000, set, 2'b00, way};
    endfunction

    function automatic int find_way(input logic [31:0] a);
        int s;
        int found;
        s = int'(a[7:4]);
        found = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == a[31:8]) begin
                found = w;
            end
        end
        return found;
    endfunction

    // Root picks the pair, the pair's leaf picks the way.
    function automatic int victim_way(input int s);
        int   pair;
        logic leaf;
        pair = model_tree[s][0] ? 2 : 0;
        leaf = model_tree[s][0] ? model_tree[s][2] : model_tree[s][1];
        return pair + int'(leaf);
    endfunction

    task automatic touch_way(input int s, input int w);
        if (w < 2) begin
            model_tree[s][0] = 1'b1;
            model_tree[s][1] = (w == 0);
        end else begin
            model_tree[s][0] = 1'b0;
            model_tree[s][2] = (w == 2);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        error_count = error_count + 1;
        $display("Mismatch %s in %s: got %h, expected %h", name, current_test, got, expected);
    endtask

    task automatic report_failure(input string what);
        error_count = error_count + 1;
        $display("Error in %s: %s", current_test, what);
    endtask

    // ====================
    // Response checks
    // ====================
    initial begin : response_check
        answered = 0;
        error_count = 0;
        forever begin
            @(negedge clk);
            if (rstn && r_req) begin
                assert (issued != answered && exp_mem)
                else report_failure("memory request raised for a predicted hit");
                assert (!cacop_ready)
                else report_failure("cacop_ready high during a memory request");
                if (exp_mem) begin
                    assert (mem_req.addr == exp_mem_addr)
                    else report_mismatch("mem_req.addr", mem_req.addr, exp_mem_addr);
                    assert (mem_req.len == exp_len)
                    else report_mismatch("mem_req.len", 32'(mem_req.len), 32'(exp_len));
                end
            end
            if (rstn && (data_valid || cacop_complete)) begin
                assert (issued != answered)
                else report_failure("response with no request outstanding");
                if (issued != answered) begin
                    assert (cacop_complete == exp_cacop)
                    else report_mismatch("cacop_complete", 32'(cacop_complete), 32'(exp_cacop));
                    if (check_rdata) begin
                        assert (rdata == exp_rdata)
                        else report_mismatch("rdata", rdata, exp_rdata);
                    end
                    if (check_rdata || exp_cacop) begin
                        assert (cache_ready && cacop_ready)
                        else report_failure("cache not ready again at the response");
                    end
                    assert ((mem_count != issue_mem_count) == exp_mem)
                    else report_failure(exp_mem ? "predicted miss made no memory request" :
                                                  "memory was read when it should not be");
                    answered = answered + 1;
                end
            end
        end
    end

    // ====================
    // Memory model
    // ====================
    initial begin : memory_model
        logic [31:0] state;
        logic [31:0] base;
        int          beats;
        int          delay;
        int          i;
        state = 32'hb03de226;
        mem_count = 0;
        r_rdy = 1'b0;
        r_data_valid = 1'b0;
        r_data = '0;
        forever begin
            @(negedge clk);
            if (rstn && r_req) begin
                mem_count = mem_count + 1;
                base = mem_req.addr;
                beats = int'(mem_req.len) + 1;
                state = lcg_step(state);
                delay = 1 + int'(state[23:16]) % 3;  // Grant after 1 to 3 cycles.
                repeat (delay) @(posedge clk);
                #10 r_rdy = 1'b1;
                @(posedge clk);
                #10 r_rdy = 1'b0;
                for (i = 0; i < beats; i++) begin
                    r_data_valid = 1'b1;
                    r_data = mem_word(base + 32'(4 * i));
                    @(posedge clk);
                    #10;
                end
                r_data_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycle_count;
        int limit;
        cycle_count = 0;
        limit = 20 * (34 + 40);  // Directed and random requests.
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Run timed out after %0d cycles", cycle_count);
        $display("TB FAILED");
        $finish;
    end

    // Drives one request, holds it until taken, then waits for its response.
    task automatic send(input logic [31:0] a, input logic unc, input logic exc,
                        input logic is_cacop, input logic [1:0] code);
        @(posedge clk);
        #10;
        addr = a;
        uncache = unc;
        exception = exc;
        cacop_code = code;
        valid = !is_cacop;
        cacop_en = is_cacop;
        issued = issued + 1;
        @(negedge clk);
        while (!(cache_ready && (!is_cacop || cacop_ready))) @(negedge clk);
        @(posedge clk);
        #10;
        valid = 1'b0;
        cacop_en = 1'b0;
        uncache = 1'b0;
        exception = 1'b0;
        while (issued != answered) @(posedge clk);
    endtask

    task automatic fetch(input logic [31:0] a, input logic unc, input logic exc);
        int s;
        int w;
        int v;
        s = int'(a[7:4]);
        w = find_way(a);
        exp_mem = !exc && (unc || w < 0);
        exp_mem_addr = unc ? {a[31:2], 2'b00} : {a[31:4], 4'h0};
        exp_len = unc ? 8'd0 : 8'd3;
        exp_rdata = mem_word(a);
        check_rdata = !exc;
        exp_cacop = 1'b0;
        issue_mem_count = mem_count;
        send(a, unc, exc, 1'b0, cacop_store_tag);
        if (!exc && !unc) begin
            if (w >= 0) begin
                touch_way(s, w);
            end else begin
                v = victim_way(s);
                model_tag[s][v] = a[31:8];
                model_valid[s][v] = 1'b1;
                touch_way(s, v);
            end
        end
    endtask

    task automatic cacop(input logic [31:0] a, input logic [1:0] code, input logic exc);
        int s;
        int w;
        s = int'(a[7:4]);
        w = (code == cacop_hit_inv) ? find_way(a) : int'(a[1:0]);
        exp_mem = 1'b0;
        exp_mem_addr = '0;
        exp_len = '0;
        exp_rdata = '0;
        check_rdata = 1'b0;
        exp_cacop = 1'b1;
        issue_mem_count = mem_count;
        send(a, 1'b0, exc, 1'b1, code);
        if (!exc && w >= 0) begin
            model_valid[s][w] = 1'b0;
        end
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        start_errors = error_count;
    endtask

    task automatic end_test();
        tests_run = tests_run + 1;
        if (error_count != start_errors) begin
            tests_failed = tests_failed + 1;
            $display("test %s: failed, %0d errors", current_test, error_count - start_errors);
        end else begin
            $display("test %s: ok", current_test);
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    initial begin : stimulus
        logic [31:0] stim_state;
        int          i;
        valid = 1'b0;
        addr = '0;
        uncache = 1'b0;
        cacop_en = 1'b0;
        cacop_code = cacop_store_tag;
        exception = 1'b0;
        issued = 0;
        tests_run = 0;
        tests_failed = 0;
        current_test = "reset";
        for (i = 0; i < num_sets; i++) begin
            model_valid[i] = '0;
            model_tree[i] = '0;
        end
        stim_state = 32'hb03de226;
        @(posedge clk);
        while (rstn !== 1'b1) @(posedge clk);

        begin_test("cold_miss_then_hit");
        fetch(line_addr(24'h000a11, 4'd1, 2'd2), 1'b0, 1'b0);
        for (i = 0; i < line_words; i++) begin
            fetch(line_addr(24'h000a11, 4'd1, 2'(i)), 1'b0, 1'b0);
        end
        end_test();

        begin_test("plru_eviction");
        for (i = 0; i < 5; i++) begin
            fetch(line_addr(24'h000200 + 24'(i), 4'd2, 2'd0), 1'b0, 1'b0);
        end
        for (i = 1; i < 5; i++) begin
            fetch(line_addr(24'h000200 + 24'(i), 4'd2, 2'd1), 1'b0, 1'b0);
        end
        fetch(line_addr(24'h000200, 4'd2, 2'd3), 1'b0, 1'b0);  // Evicted tag.
        end_test();

        begin_test("uncached_fetch");
        fetch(line_addr(24'h000333, 4'd3, 2'd1), 1'b1, 1'b0);
        fetch(line_addr(24'h000333, 4'd3, 2'd1), 1'b0, 1'b0);
        fetch(line_addr(24'h000333, 4'd3, 2'd1), 1'b0, 1'b0);
        fetch(line_addr(24'h000333, 4'd3, 2'd1), 1'b1, 1'b0);
        end_test();

        begin_test("cacop_invalidate");
        for (i = 0; i < num_ways; i++) begin
            fetch(line_addr(24'h000500 + 24'(i), 4'd5, 2'd0), 1'b0, 1'b0);
        end
        cacop(maint_addr(4'd5, 2'd2), cacop_index_inv, 1'b0);
        fetch(line_addr(model_tag[5][2], 4'd5, 2'd0), 1'b0, 1'b0);
        cacop(maint_addr(4'd5, 2'd3), cacop_store_tag, 1'b0);
        fetch(line_addr(model_tag[5][3], 4'd5, 2'd1), 1'b0, 1'b0);
        cacop(line_addr(24'h000502, 4'd5, 2'd0), cacop_hit_inv, 1'b0);
        fetch(line_addr(24'h000502, 4'd5, 2'd3), 1'b0, 1'b0);
        end_test();

        begin_test("exception_cancel");
        fetch(line_addr(24'h000777, 4'd7, 2'd0), 1'b0, 1'b1);
        fetch(line_addr(24'h000777, 4'd7, 2'd0), 1'b0, 1'b0);
        fetch(line_addr(24'h000777, 4'd7, 2'd2), 1'b0, 1'b1);
        cacop(line_addr(24'h000777, 4'd7, 2'd0), cacop_hit_inv, 1'b1);
        fetch(line_addr(24'h000777, 4'd7, 2'd1), 1'b0, 1'b0);
        end_test();

        // Eight tags over four sets keep the PLRU busy.
        begin_test("random_mix");
        for (i = 0; i < 40; i++) begin
            stim_state = lcg_step(stim_state);
            fetch(line_addr(24'h000c00 + 24'(stim_state[12:10]), {2'b00, stim_state[9:8]},
                            stim_state[15:14]),
                  stim_state[19:17] == 3'd0, 1'b0);
        end
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period.
    end

    // Reset held for four rising edges.
    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        #10 rstn = 1'b1;
    end

endmodule

//--- build.f
hw/icache_pkg.sv
hw/icache_req_buffer.sv
hw/icache_tag_store.sv
hw/icache_data_store.sv
hw/icache_plru.sv
hw/icache_refill_buffer.sv
hw/icache_fsm.sv
hw/icache_top.sv
bench/tb_clock_gen.sv
bench/icache_fsm_asserts.sv
bench/icache_tb.sv

//--- hw/icache_data_store.sv
`timescale 1ns/100ps

module icache_data_store
    import icache_pkg::*;
(
    input  logic        clk,
    input  icache_req_t req,
    input  way_mask_t   mem_we,
    input  line_t       fill_line,
    input  way_mask_t   hit,
    output logic [31:0] hit_word
);

    line_t                    data_q [num_ways][num_sets];
    logic [index_bits-1:0]    index;
    logic [word_sel_bits-1:0] word_sel;

    assign index    = req.addr.fetch.index;
    assign word_sel = req.addr.fetch.offset[offset_bits-1 -: word_sel_bits];

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (mem_we[w]) begin
                data_q[w][index] <= fill_line;  // Whole line.
            end
        end
    end

    // Hit mask is one-hot, so an OR picks the way.
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit[w]) begin
                hit_word = hit_word | data_q[w][index][word_sel];
            end
        end
    end

endmodule

//--- hw/icache_fsm.sv
`timescale 1ns/100ps

module icache_fsm
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        valid,
    input  logic        cacop_en,
    input  icache_req_t req,
    input  logic        cache_hit,
    input  way_mask_t   hit,
    input  way_mask_t   lru_way_sel,
    input  logic        r_rdy,
    input  logic        fill_finish,
    output logic        rbuf_we,
    output logic        rdata_sel,
    output way_mask_t   way_visit,
    output logic        way_sel_en,
    output way_mask_t   tagv_we,
    output logic        tagv_clear,
    output way_mask_t   mem_we,
    output logic        r_req,
    output mem_req_t    mem_req,
    output logic        r_data_ready,
    output logic        data_valid,
    output logic        cache_ready,
    output logic        cacop_ready,
    output logic        cacop_complete
);

    logic [2:0] state_q;
    logic [2:0] state_d;
    way_mask_t  index_way;

    // Way named by an index-type cacop.
    always_comb begin
        index_way = '0;
        index_way[req.addr.maint.way] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= state_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // ==================
    // Next state
    // ==================
    always_comb begin
        state_d = state_idle;
        case (state_q)
            state_idle, state_extra_ready: begin
                if (cacop_en) begin
                    state_d = state_cacop;
                end else if (valid) begin
                    state_d = state_lookup;
                end
            end
            state_lookup: begin
                if (req.exception) begin
                    state_d = state_idle;
                end else if (req.uncache || !cache_hit) begin
                    state_d = state_replace;
                end else if (cacop_en) begin
                    state_d = state_cacop;
                end else if (valid) begin
                    state_d = state_lookup;  // Back-to-back hits.
                end
            end
            state_replace: state_d = r_rdy ? state_refill : state_replace;
            state_refill:  state_d = fill_finish ? state_extra_ready : state_refill;
            state_cacop:   state_d = state_extra_ready;
            default:       state_d = state_idle;
        endcase
    end

    // ==================
    // Outputs
    // ==================
    always_comb begin
        rbuf_we        = 1'b0;
        rdata_sel      = 1'b0;
        way_visit      = '0;
        way_sel_en     = 1'b0;
        tagv_we        = '0;
        tagv_clear     = 1'b0;
        mem_we         = '0;
        r_req          = 1'b0;
        r_data_ready   = 1'b0;
        data_valid     = 1'b0;
        cache_ready    = 1'b0;
        cacop_ready    = 1'b0;
        cacop_complete = 1'b0;
        case (state_q)
            state_idle: begin
                rbuf_we     = 1'b1;
                cache_ready = 1'b1;
                cacop_ready = 1'b1;
            end
            state_lookup: begin
                if (req.exception) begin
                    data_valid = 1'b1;  // Cancelled fetch.
                end else if (cache_hit && !req.uncache) begin
                    rdata_sel   = 1'b1;
                    data_valid  = 1'b1;
                    rbuf_we     = 1'b1;
                    way_visit   = hit;
                    way_sel_en  = 1'b1;
                    cache_ready = 1'b1;
                    cacop_ready = 1'b1;
                end
            end
            state_replace: r_req = 1'b1;
            state_refill: begin
                r_data_ready = 1'b1;
                if (fill_finish && !req.uncache) begin
                    mem_we     = lru_way_sel;
                    tagv_we    = lru_way_sel;
                    way_visit  = lru_way_sel;
                    way_sel_en = 1'b1;
                end
            end
            state_cacop: begin
                if (!req.exception) begin
                    tagv_clear = 1'b1;
                    if (req.cacop_code == cacop_store_tag ||
                        req.cacop_code == cacop_index_inv) begin
                        tagv_we = index_way;
                    end else if (req.cacop_code == cacop_hit_inv) begin
                        tagv_we = hit;
                    end
                end
            end
            state_extra_ready: begin
                data_valid     = 1'b1;
                rbuf_we        = 1'b1;
                cache_ready    = 1'b1;
                cacop_ready    = 1'b1;
                cacop_complete = req.cacop_en;
            end
            default: ;
        endcase
    end

    // Line address for a miss, word address when uncached.
    always_comb begin
        if (req.uncache) begin
            mem_req.addr = {req.addr[31:2], 2'b00};
            mem_req.len  = 8'd0;
        end else begin
            mem_req.addr = {req.addr.fetch.tag, req.addr.fetch.index, {offset_bits{1'b0}}};
            mem_req.len  = 8'(line_words - 1);
        end
    end

endmodule

//--- hw/icache_pkg.sv
package icache_pkg;

    // ==================
    // Geometry
    // ==================
    localparam int num_ways      = 4;
    localparam int num_sets      = 16;
    localparam int line_words    = 4;
    localparam int offset_bits   = 4;  // Byte offset in a line.
    localparam int index_bits    = 4;
    localparam int tag_bits      = 24;
    localparam int word_sel_bits = 2;  // Word within a line.
    localparam int way_bits      = 2;

    // Maintenance operations.
    localparam logic [1:0] cacop_store_tag = 2'd0;
    localparam logic [1:0] cacop_index_inv = 2'd1;
    localparam logic [1:0] cacop_hit_inv   = 2'd2;

    // FSM state codes.
    localparam logic [2:0] state_idle        = 3'd0;
    localparam logic [2:0] state_lookup      = 3'd1;
    localparam logic [2:0] state_replace     = 3'd2;
    localparam logic [2:0] state_refill      = 3'd3;
    localparam logic [2:0] state_cacop       = 3'd4;
    localparam logic [2:0] state_extra_ready = 3'd5;

    // ==================
    // Types
    // ==================
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;
    } fetch_addr_t;

    // Index-type cacops name the way in the low bits.
    typedef struct packed {
        logic [tag_bits-1:0]             tag;
        logic [index_bits-1:0]           index;
        logic [offset_bits-way_bits-1:0] unused;
        logic [way_bits-1:0]             way;
    } maint_addr_t;

    typedef union packed {
        fetch_addr_t fetch;
        maint_addr_t maint;
    } icache_addr_u;

    typedef struct packed {
        icache_addr_u addr;
        logic         uncache;
        logic         cacop_en;
        logic [1:0]   cacop_code;
        logic         exception;
    } icache_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;  // Beats minus one.
    } mem_req_t;

    typedef logic [line_words-1:0][31:0] line_t;

    typedef logic [num_ways-1:0] way_mask_t;

endpackage

//--- hw/icache_plru.sv
`timescale 1ns/100ps

module icache_plru
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  icache_req_t req,
    input  logic        way_sel_en,
    input  way_mask_t   way_visit,
    output way_mask_t   lru_way_sel
);

    // Bit 0 is the root, bit 1 splits ways 0/1, bit 2 splits ways 2/3.
    logic [2:0]            tree_q [num_sets];
    logic [2:0]            tree;
    logic [index_bits-1:0] index;

    assign index = req.addr.fetch.index;
    assign tree  = tree_q[index];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < num_sets; s++) begin
                tree_q[s] <= '0;
            end
        end else if (way_sel_en) begin
            if (way_visit[0] || way_visit[1]) begin
                tree_q[index][0] <= 1'b1;          // Point at the other pair.
                tree_q[index][1] <= way_visit[0];
            end else if (way_visit[2] || way_visit[3]) begin
                tree_q[index][0] <= 1'b0;
                tree_q[index][2] <= way_visit[2];
            end
        end
    end

    always_comb begin
        if (!tree[0]) begin
            lru_way_sel = tree[1] ? 4'b0010 : 4'b0001;
        end else begin
            lru_way_sel = tree[2] ? 4'b1000 : 4'b0100;
        end
    end

endmodule

//--- hw/icache_refill_buffer.sv
`timescale 1ns/100ps

module icache_refill_buffer
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        r_data_ready,
    input  logic        r_data_valid,
    input  logic [31:0] r_data,
    input  logic        uncache,
    output line_t       line,
    output logic        fill_finish
);

    logic [word_sel_bits-1:0] count_q;
    line_t                    line_q;
    logic                     beat;

    assign beat        = r_data_ready && r_data_valid;
    assign fill_finish = beat && (uncache || count_q == word_sel_bits'(line_words - 1));

    // Last beat shows up at once so the arrays can take the line.
    assign line = beat ? {r_data, line_q[line_words-1:1]} : line_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count_q <= '0;
        end else if (fill_finish) begin
            count_q <= '0;
        end else if (beat) begin
            count_q <= count_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            line_q <= line;  // Shift in from the top.
        end
    end

endmodule

//--- hw/icache_req_buffer.sv
`timescale 1ns/100ps

module icache_req_buffer
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    input  logic         rbuf_we,
    input  logic         valid,
    input  logic         cacop_en,
    input  logic         uncache,
    input  logic         exception,
    input  logic [1:0]   cacop_code,
    input  icache_addr_u addr,
    output icache_req_t  req
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req.uncache    <= 1'b0;
            req.cacop_en   <= 1'b0;
            req.cacop_code <= cacop_store_tag;
            req.exception  <= 1'b0;
        end else if (rbuf_we) begin
            if (valid || cacop_en) begin
                req.addr       <= addr;
                req.uncache    <= uncache;
                req.cacop_en   <= cacop_en;
                req.cacop_code <= cacop_code;
                req.exception  <= exception;
            end else begin
                // Nothing taken, so no cacop is pending.
                req.cacop_en <= 1'b0;
            end
        end
    end

endmodule

//--- hw/icache_tag_store.sv
`timescale 1ns/100ps

module icache_tag_store
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  icache_req_t req,
    input  way_mask_t   tagv_we,
    input  logic        tagv_clear,
    output way_mask_t   hit,
    output logic        cache_hit
);

    logic [tag_bits-1:0]   tag_q [num_ways][num_sets];
    logic [num_sets-1:0]   valid_q [num_ways];
    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   tag;

    assign index = req.addr.fetch.index;
    assign tag   = req.addr.fetch.tag;

    // ==================
    // Valid bits
    // ==================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < num_ways; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (tagv_we[w]) begin
                    valid_q[w][index] <= !tagv_clear;  // Clear or fill.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (tagv_we[w] && !tagv_clear) begin
                tag_q[w][index] <= tag;
            end
        end
    end

    // Compare all ways at once.
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit[w] = valid_q[w][index] && (tag_q[w][index] == tag);
        end
    end

    assign cache_hit = |hit;

endmodule

//--- hw/icache_top.sv
`timescale 1ns/100ps

module icache_top
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    // Fetch side.
    input  logic         valid,
    input  icache_addr_u addr,
    input  logic         uncache,
    input  logic         cacop_en,
    input  logic [1:0]   cacop_code,
    input  logic         exception,
    output logic         cache_ready,
    output logic         cacop_ready,
    output logic         data_valid,
    output logic [31:0]  rdata,
    output logic         cacop_complete,
    // Memory read port.
    output logic         r_req,
    output mem_req_t     mem_req,
    input  logic         r_rdy,
    input  logic         r_data_valid,
    input  logic [31:0]  r_data
);

    icache_req_t              req;
    way_mask_t                hit;
    way_mask_t                lru_way_sel;
    way_mask_t                way_visit;
    way_mask_t                tagv_we;
    way_mask_t                mem_we;
    logic                     cache_hit;
    logic                     rbuf_we;
    logic                     rdata_sel;
    logic                     way_sel_en;
    logic                     tagv_clear;
    logic                     r_data_ready;
    logic                     fill_finish;
    line_t                    fill_line;
    logic [31:0]              hit_word;
    logic [31:0]              refill_word;
    logic [word_sel_bits-1:0] word_sel;

    icache_req_buffer u_req_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .rbuf_we    (rbuf_we),
        .valid      (valid),
        .cacop_en   (cacop_en),
        .uncache    (uncache),
        .exception  (exception),
        .cacop_code (cacop_code),
        .addr       (addr),
        .req        (req)
    );

    icache_tag_store u_tag_store (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .tagv_we    (tagv_we),
        .tagv_clear (tagv_clear),
        .hit        (hit),
        .cache_hit  (cache_hit)
    );

    icache_data_store u_data_store (
        .clk       (clk),
        .req       (req),
        .mem_we    (mem_we),
        .fill_line (fill_line),
        .hit       (hit),
        .hit_word  (hit_word)
    );

    icache_plru u_plru (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .way_sel_en  (way_sel_en),
        .way_visit   (way_visit),
        .lru_way_sel (lru_way_sel)
    );

    icache_refill_buffer u_refill_buffer (
        .clk          (clk),
        .rstn         (rstn),
        .r_data_ready (r_data_ready),
        .r_data_valid (r_data_valid),
        .r_data       (r_data),
        .uncache      (req.uncache),
        .line         (fill_line),
        .fill_finish  (fill_finish)
    );

    icache_fsm u_fsm (
        .clk            (clk),
        .rstn           (rstn),
        .valid          (valid),
        .cacop_en       (cacop_en),
        .req            (req),
        .cache_hit      (cache_hit),
        .hit            (hit),
        .lru_way_sel    (lru_way_sel),
        .r_rdy          (r_rdy),
        .fill_finish    (fill_finish),
        .rbuf_we        (rbuf_we),
        .rdata_sel      (rdata_sel),
        .way_visit      (way_visit),
        .way_sel_en     (way_sel_en),
        .tagv_we        (tagv_we),
        .tagv_clear     (tagv_clear),
        .mem_we         (mem_we),
        .r_req          (r_req),
        .mem_req        (mem_req),
        .r_data_ready   (r_data_ready),
        .data_valid     (data_valid),
        .cache_ready    (cache_ready),
        .cacop_ready    (cacop_ready),
        .cacop_complete (cacop_complete)
    );

    // ==================
    // Read data mux
    // ==================
    assign word_sel = req.addr.fetch.offset[offset_bits-1 -: word_sel_bits];

    // An uncached beat lands in the top word.
    assign refill_word = req.uncache ? fill_line[line_words-1] : fill_line[word_sel];
    assign rdata       = rdata_sel ? hit_word : refill_word;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module icache_tb -f build.f \
    --Mdir obj_dir -o icache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/icache_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx 'TB PASSED'; then
    exit 0
fi
exit 1
